// File: src/cache_cfg_pkg.sv
package cache_cfg_pkg;

    // Geometry of the direct-mapped data cache
    localparam int WORDS_PER_LINE = 4;  // Beats per write-back or refill
    localparam int NUM_LINES      = 2;  // Lines selected by address bit 4

    // Address split
    //   31..5 tag, 4 index, 3..2 word offset, 1..0 byte offset
    typedef logic [31:0] word_t;    // Addresses and data words
    typedef logic [26:0] tag_t;     // Address bits 31..5
    typedef logic [0:0]  index_t;   // Address bit 4
    typedef logic [1:0]  offset_t;  // Address bits 3..2, also the beat index

endpackage

// File: src/cache_op_pkg.sv
package cache_op_pkg;

    // Access size, encoded exactly as the RV32 load/store funct3 field
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,  // Signed byte
        SZ_H  = 3'b001,  // Signed halfword
        SZ_W  = 3'b010,  // Word
        SZ_BU = 3'b100,  // Unsigned byte, loads only
        SZ_HU = 3'b101   // Unsigned halfword, loads only
    } size_e;

    // Miss handling controller
    typedef enum logic [2:0] {
        IDLE,        // Waiting for a CPU request
        LOOKUP,      // Tag compare on the latched address
        WRITEBACK,   // Dirty victim goes out one word per cycle
        REFILL_REQ,  // Single read strobe, new tag installed
        REFILL,      // Collecting the four returned words
        RESPOND      // Store merge and done strobe
    } ctrl_state_e;

endpackage

// File: src/cache_store_if.sv
interface cache_store_if;
    import cache_cfg_pkg::*;
    import cache_op_pkg::*;

    // Driven by the controller
    word_t   req_addr;      // Latched request address
    word_t   req_wdata;     // Latched store data
    size_e   req_size;      // Latched access size
    logic    store_en;      // Merge the latched store into the line
    logic    fill_tag_en;   // Install tag, valid and clean
    logic    beat_step;     // Advance the beat counter
    logic    beat_clear;    // Restart at beat 0
    logic    fill_we;       // Write one refill word

    // Driven by the tag/data store
    logic    hit;
    logic    victim_dirty;
    word_t   victim_addr;   // Base address of the resident line
    word_t   beat_word;     // Resident word at the current beat
    word_t   load_data;     // Extended load result

    // Driven by the beat counter
    offset_t beat;
    logic    last_beat;

    modport ctrl (
        output req_addr, req_wdata, req_size,
        output store_en, fill_tag_en, beat_step, beat_clear, fill_we,
        input  hit, victim_dirty, last_beat
    );

    modport count (
        input  beat_step, beat_clear,
        output beat, last_beat
    );

    modport store (
        input  req_addr, req_wdata, req_size,
        input  store_en, fill_tag_en, fill_we, beat,
        output hit, victim_dirty, victim_addr, beat_word, load_data
    );

endinterface

// File: src/cache_fsm.sv
module cache_fsm (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cpu_req,
    input  logic                 cpu_we,
    input  cache_cfg_pkg::word_t cpu_addr,
    input  cache_cfg_pkg::word_t cpu_wdata,
    input  cache_op_pkg::size_e  cpu_funct3,
    output logic                 busy,
    output logic                 cpu_done,
    output logic                 mem_wr,
    output logic                 mem_rd,
    input  logic                 mem_rvalid,
    cache_store_if.ctrl          st
);
    import cache_op_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        req_we;   // Held write flag of the current access
    logic        accept;   // Request taken this cycle

    assign accept = cpu_req && (state == IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= IDLE;
            req_we <= 1'b0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                req_we <= cpu_we;
            end
        end
    end

    // Request payload latch
    always_ff @(posedge clk) begin
        if (accept) begin
            st.req_addr  <= cpu_addr;
            st.req_wdata <= cpu_wdata;
            st.req_size  <= cpu_funct3;
        end
    end

    always_comb begin
        state_nxt      = state;
        busy           = (state != IDLE);
        cpu_done       = 1'b0;
        mem_wr         = 1'b0;
        mem_rd         = 1'b0;
        st.store_en    = 1'b0;
        st.fill_tag_en = 1'b0;
        st.beat_step   = 1'b0;
        st.beat_clear  = 1'b0;
        st.fill_we     = 1'b0;

        case (state)
            IDLE: begin
                if (cpu_req) begin
                    state_nxt = LOOKUP;
                end
            end
            LOOKUP: begin
                st.beat_clear = 1'b1;            // Both miss paths start at word 0
                if (st.hit) begin
                    state_nxt = RESPOND;
                end else if (st.victim_dirty) begin
                    state_nxt = WRITEBACK;
                end else begin
                    state_nxt = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                mem_wr       = 1'b1;             // One word per cycle, no stall
                st.beat_step = 1'b1;
                if (st.last_beat) begin
                    state_nxt = REFILL_REQ;      // Counter wraps back to 0
                end
            end
            REFILL_REQ: begin
                mem_rd         = 1'b1;
                st.fill_tag_en = 1'b1;
                state_nxt      = REFILL;
            end
            REFILL: begin
                // Memory may hold off mem_rvalid for any number of cycles
                if (mem_rvalid) begin
                    st.fill_we   = 1'b1;
                    st.beat_step = 1'b1;
                    if (st.last_beat) begin
                        state_nxt = RESPOND;
                    end
                end
            end
            RESPOND: begin
                cpu_done    = 1'b1;
                st.store_en = req_we;            // Merge lands on the closing edge
                state_nxt   = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

endmodule

// File: src/beat_counter.sv
module beat_counter (
    input logic          clk,
    input logic          arst_n,
    cache_store_if.count cnt
);
    import cache_cfg_pkg::*;

    // Shared by write-back addressing and the refill word slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt.beat <= '0;
        end else if (cnt.beat_clear) begin
            cnt.beat <= '0;
        end else if (cnt.beat_step) begin
            cnt.beat <= cnt.beat + 1'b1;  // Wraps after the fourth word
        end
    end

    assign cnt.last_beat = (cnt.beat == offset_t'(WORDS_PER_LINE - 1));

endmodule

// File: src/cache_store.sv
module cache_store (
    input logic                 clk,
    input logic                 arst_n,
    input cache_cfg_pkg::word_t mem_rdata,
    cache_store_if.store        st
);
    import cache_cfg_pkg::*;
    import cache_op_pkg::*;

    tag_t                 tag_mem  [NUM_LINES];
    word_t                data_mem [NUM_LINES][WORDS_PER_LINE];
    logic [NUM_LINES-1:0] valid;
    logic [NUM_LINES-1:0] dirty;

    tag_t       req_tag;
    index_t     idx;
    offset_t    off;
    logic [1:0] byte_off;   // Byte lane within the word
    word_t      cur_word;   // Addressed word of the indexed line
    word_t      merged;     // Addressed word with the store applied
    word_t      shifted;    // Addressed word aligned to the byte lane

    assign req_tag  = st.req_addr[31:5];
    assign idx      = st.req_addr[4];
    assign off      = st.req_addr[3:2];
    assign byte_off = st.req_addr[1:0];
    assign cur_word = data_mem[idx][off];

    assign st.hit          = valid[idx] && (tag_mem[idx] == req_tag);
    assign st.victim_dirty = valid[idx] && dirty[idx];
    assign st.victim_addr  = {tag_mem[idx], idx, 4'b0000};
    assign st.beat_word    = data_mem[idx][st.beat];

    // Store merge into the byte lane
    always_comb begin
        merged = cur_word;
        case (st.req_size)
            SZ_B: begin
                merged[8*byte_off +: 8] = st.req_wdata[7:0];
            end
            SZ_H: begin
                merged[16*byte_off[1] +: 16] = st.req_wdata[15:0];
            end
            SZ_W: begin
                merged = st.req_wdata;
            end
            default: begin
                merged = cur_word;  // Other funct3 codes leave the word alone
            end
        endcase
    end

    // Load extraction and extension
    always_comb begin
        shifted = cur_word >> {byte_off, 3'b000};
        case (st.req_size)
            SZ_B: begin
                st.load_data = {{24{shifted[7]}}, shifted[7:0]};
            end
            SZ_H: begin
                st.load_data = {{16{shifted[15]}}, shifted[15:0]};
            end
            SZ_W: begin
                st.load_data = cur_word;
            end
            SZ_BU: begin
                st.load_data = {24'h000000, shifted[7:0]};
            end
            SZ_HU: begin
                st.load_data = {16'h0000, shifted[15:0]};
            end
            default: begin
                st.load_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            dirty <= '0;
            for (int i = 0; i < NUM_LINES; i++) begin
                tag_mem[i] <= '0;
                for (int j = 0; j < WORDS_PER_LINE; j++) begin
                    data_mem[i][j] <= '0;
                end
            end
        end else begin
            if (st.fill_tag_en) begin
                tag_mem[idx] <= req_tag;
                valid[idx]   <= 1'b1;
                dirty[idx]   <= 1'b0;                 // Fresh line matches memory
            end
            if (st.fill_we) begin
                data_mem[idx][st.beat] <= mem_rdata;  // Ascending word order
            end
            if (st.store_en) begin
                data_mem[idx][off] <= merged;
                dirty[idx]         <= 1'b1;
            end
        end
    end

endmodule

// File: src/dcache_top.sv
module dcache_top (
    input  logic                 clk,
    input  logic                 arst_n,
    // CPU side
    input  logic                 cpu_req,
    input  logic                 cpu_we,
    input  cache_cfg_pkg::word_t cpu_addr,
    input  cache_cfg_pkg::word_t cpu_wdata,
    input  cache_op_pkg::size_e  cpu_funct3,
    output logic                 busy,
    output logic                 cpu_done,
    output cache_cfg_pkg::word_t cpu_rdata,
    // Memory side
    output logic                 mem_wr,
    output logic                 mem_rd,
    output cache_cfg_pkg::word_t mem_addr,
    output cache_cfg_pkg::word_t mem_wdata,
    input  logic                 mem_rvalid,
    input  cache_cfg_pkg::word_t mem_rdata
);

    cache_store_if st ();

    cache_fsm u_fsm (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_funct3 (cpu_funct3),
        .busy       (busy),
        .cpu_done   (cpu_done),
        .mem_wr     (mem_wr),
        .mem_rd     (mem_rd),
        .mem_rvalid (mem_rvalid),
        .st         (st)
    );

    beat_counter u_beat (
        .clk    (clk),
        .arst_n (arst_n),
        .cnt    (st)
    );

    cache_store u_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_rdata (mem_rdata),
        .st        (st)
    );

    // Victim word address while writing back, otherwise the requested line base
    assign mem_addr  = mem_wr ? (st.victim_addr + {st.beat, 2'b00})
                              : {st.req_addr[31:4], 4'b0000};
    assign mem_wdata = st.beat_word;
    assign cpu_rdata = st.load_data;

endmodule

// File: verification/dcache_checker.sv
module dcache_checker (
    input logic clk,
    input logic arst_n,
    input logic cpu_req,
    input logic busy,
    input logic cpu_done,
    input logic mem_wr,
    input logic mem_rd
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;  // Failed assertions, summed into the run result

    // Memory strobes are one direction at a time
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(mem_wr && mem_rd)
    ) else begin
        fail_cnt++;
        $error("mem_wr and mem_rd were high in the same cycle");
    end

    done_single: assert property (
        @(posedge clk) disable iff (!arst_n) cpu_done |=> !cpu_done
    ) else begin
        fail_cnt++;
        $error("cpu_done stayed high for more than one cycle");
    end

    req_while_idle: assert property (
        @(posedge clk) disable iff (!arst_n) !(cpu_req && busy)
    ) else begin
        fail_cnt++;
        $error("cpu_req was raised while the cache was busy");
    end

endmodule

bind dcache_top dcache_checker u_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .cpu_req  (cpu_req),
    .busy     (busy),
    .cpu_done (cpu_done),
    .mem_wr   (mem_wr),
    .mem_rd   (mem_rd)
);

// File: verification/dcache_tb.sv
module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_cfg_pkg::*;
    import cache_op_pkg::*;

    localparam word_t BASE_ADDR = 32'h0000_2000;
    localparam int    SPAN      = 128;  // 4 tags x 2 lines x 16 bytes
    localparam int    TIMEOUT   = 200;  // Cycles allowed for any single wait

    logic  clk;
    logic  arst_n;
    logic  cpu_req;
    logic  cpu_we;
    word_t cpu_addr;
    word_t cpu_wdata;
    size_e cpu_funct3;
    logic  busy;
    logic  cpu_done;
    word_t cpu_rdata;
    logic  mem_wr;
    logic  mem_rd;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_rvalid;
    word_t mem_rdata;

    logic [7:0]  mem_img [SPAN];  // Backing memory behind the cache
    logic [7:0]  ref_img [SPAN];  // Architectural value of every byte
    logic [31:0] lfsr;
    logic [1:0]  gaps [WORDS_PER_LINE];  // Idle cycles before each refill word
    word_t       wr_addr [WORDS_PER_LINE];
    word_t       wr_data [WORDS_PER_LINE];
    word_t       rd_addr;
    int          wr_cnt;
    int          rd_cnt;
    int          wr_before_rd;  // Write-backs seen when mem_rd arrived
    int          last_lat;
    int          err_cnt   = 0;
    int          check_cnt = 0;
    int          test_cnt  = 0;
    int          test_fail = 0;

    dcache_top DUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_req    (cpu_req),
        .cpu_we     (cpu_we),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_funct3 (cpu_funct3),
        .busy       (busy),
        .cpu_done   (cpu_done),
        .cpu_rdata  (cpu_rdata),
        .mem_wr     (mem_wr),
        .mem_rd     (mem_rd),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32, 22, 2, 1
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic [7:0] addr_hash(input word_t a);
        word_t h;
        h = a * 32'h9e37_79b1;
        h = h ^ (h >> 15) ^ (a << 3);
        return h[7:0] ^ h[23:16];
    endfunction

    function automatic word_t make_addr(input int tsel, input int idx, input int woff,
                                        input int boff);
        return BASE_ADDR + word_t'(tsel * 32 + idx * 16 + woff * 4 + boff);
    endfunction

    function automatic bit in_range(input word_t a);
        return (a >= BASE_ADDR) && (a < BASE_ADDR + SPAN);
    endfunction

    function automatic word_t ref_word(input word_t a);
        int i;
        i = int'((a & ~32'h3) - BASE_ADDR);
        return {ref_img[i+3], ref_img[i+2], ref_img[i+1], ref_img[i]};
    endfunction

    // Little endian: byte offset k sits in bits 8k+7..8k
    function automatic word_t expected_load(input word_t a, input size_e f3);
        int          i;
        logic [7:0]  b;
        logic [15:0] h;
        i = int'(a - BASE_ADDR);
        b = ref_img[i];
        h = {ref_img[i+1], ref_img[i]};
        case (f3)
            SZ_B:    return {{24{b[7]}}, b};
            SZ_H:    return {{16{h[15]}}, h};
            SZ_W:    return ref_word(a);
            SZ_BU:   return {24'h0, b};
            SZ_HU:   return {16'h0, h};
            default: return '0;  // Unsupported load code reads as zero
        endcase
    endfunction

    function automatic void apply_store(input word_t a, input word_t d, input size_e f3);
        int i;
        i = int'(a - BASE_ADDR);
        case (f3)
            SZ_B: ref_img[i] = d[7:0];
            SZ_H: begin
                ref_img[i]   = d[7:0];
                ref_img[i+1] = d[15:8];
            end
            SZ_W: begin
                for (int k = 0; k < 4; k++) begin
                    ref_img[i+k] = d[8*k +: 8];
                end
            end
            default: ;  // No data change for other store codes
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_strobe(input logic got, input logic exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("MISMATCH at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    task automatic abort_run(input string why);
        $display("Run stopped at %0t: %s", $time, why);
        $display("** FAIL **");
        $finish;
    endtask

    // Memory model, applies write-backs and answers each mem_rd with a line
    task automatic serve_refill(input word_t base);
        int i;
        @(negedge clk);  // REFILL starts after the edge that ends REFILL_REQ
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            mem_rvalid = 1'b0;
            repeat (gaps[b]) @(negedge clk);
            i          = int'(base - BASE_ADDR) + 4 * b;
            mem_rdata  = in_range(base) ? {mem_img[i+3], mem_img[i+2], mem_img[i+1], mem_img[i]}
                                        : '0;
            mem_rvalid = 1'b1;
            @(negedge clk);
        end
        mem_rvalid = 1'b0;
    endtask

    initial begin
        int i;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(negedge clk);
            if (mem_wr) begin
                if (wr_cnt < WORDS_PER_LINE) begin
                    wr_addr[wr_cnt] = mem_addr;
                    wr_data[wr_cnt] = mem_wdata;
                end
                wr_cnt++;
                if (in_range(mem_addr)) begin
                    i = int'(mem_addr - BASE_ADDR);
                    for (int k = 0; k < 4; k++) begin
                        mem_img[i+k] = mem_wdata[8*k +: 8];
                    end
                end else begin
                    err_cnt++;
                    $display("Memory write outside the test range at %0t", $time);
                end
            end
            if (mem_rd) begin
                rd_cnt++;
                rd_addr      = mem_addr;
                wr_before_rd = wr_cnt;
                serve_refill(mem_addr);
            end
        end
    end

    // One CPU access, request driven on a falling edge while the cache is idle
    task automatic access(input logic we, input word_t addr, input word_t wdata,
                          input size_e f3, output word_t rdata);
        int waited;
        waited = 0;
        while (busy) begin
            if (waited >= TIMEOUT) abort_run("cache never became idle for a new request");
            @(negedge clk);
            waited++;
        end
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            gaps[b] = 2'(rand_bits(2));
        end
        wr_cnt       = 0;
        rd_cnt       = 0;
        wr_before_rd = -1;
        cpu_req      = 1'b1;
        cpu_we       = we;
        cpu_addr     = addr;
        cpu_wdata    = wdata;
        cpu_funct3   = f3;
        @(negedge clk);
        cpu_req  = 1'b0;
        last_lat = 1;
        while (!cpu_done) begin
            if (last_lat >= TIMEOUT) abort_run("cpu_done did not arrive after a request");
            check_strobe(busy, 1'b1, "busy while the access is pending");
            @(negedge clk);
            last_lat++;
        end
        check_strobe(busy, 1'b1, "busy in the cpu_done cycle");
        rdata = cpu_rdata;
        @(negedge clk);  // Back in IDLE
        check_strobe(busy, 1'b0, "busy after cpu_done");
    endtask

    task automatic load_check(input word_t addr, input size_e f3, input string msg);
        word_t exp;
        word_t rdata;
        exp = expected_load(addr, f3);
        access(1'b0, addr, '0, f3, rdata);
        check_word(rdata, exp, $sformatf("%s at %h", msg, addr));
    endtask

    task automatic store_ref(input word_t addr, input word_t data, input size_e f3);
        word_t rdata;
        access(1'b1, addr, data, f3, rdata);
        apply_store(addr, data, f3);
    endtask

    task automatic expect_hit(input string msg);
        check_word(word_t'(last_lat), 32'd2, {msg, " hit latency"});
        check_strobe(wr_cnt != 0, 1'b0, {msg, " mem_wr during hit"});
        check_strobe(rd_cnt != 0, 1'b0, {msg, " mem_rd during hit"});
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail++;
            $display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int         errs;
        int         asrt;
        word_t      r;
        word_t      old_line [WORDS_PER_LINE];
        int         boff;
        logic [2:0] code;
        size_e      f3;
        arst_n     = 1'b0;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_funct3 = SZ_W;
        lfsr       = 32'hd9eb6dad;
        for (int i = 0; i < SPAN; i++) begin
            mem_img[i] = addr_hash(BASE_ADDR + word_t'(i));
            ref_img[i] = mem_img[i];
        end
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        check_strobe(busy, 1'b0, "busy after reset");
        check_strobe(cpu_done, 1'b0, "cpu_done after reset");
        check_strobe(mem_wr | mem_rd, 1'b0, "memory strobes after reset");

        errs = err_cnt;
        load_check(make_addr(0, 0, 1, 0), SZ_W, "cold load");
        check_word(word_t'(rd_cnt), 32'd1, "mem_rd count on cold miss");
        check_word(rd_addr, make_addr(0, 0, 0, 0), "refill line base");
        check_word(word_t'(wr_cnt), 32'd0, "mem_wr count on cold miss");
        finish_test("cold load miss", errs);

        errs = err_cnt;
        store_ref(make_addr(0, 0, 2, 1), rand_bits(32) | 32'h80, SZ_B);
        expect_hit("byte store");
        load_check(make_addr(0, 0, 2, 0), SZ_W, "load after store");
        expect_hit("word load");
        finish_test("store then load hit", errs);

        errs = err_cnt;
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            old_line[b] = ref_word(make_addr(0, 0, b, 0));
        end
        load_check(make_addr(1, 0, 3, 0), SZ_W, "load over dirty victim");
        check_word(word_t'(wr_cnt), 32'd4, "write-back beat count");
        for (int b = 0; b < WORDS_PER_LINE; b++) begin
            check_word(wr_addr[b], make_addr(0, 0, b, 0), $sformatf("write-back addr %0d", b));
            check_word(wr_data[b], old_line[b], $sformatf("write-back data %0d", b));
        end
        check_word(word_t'(wr_before_rd), 32'd4, "write-back before mem_rd");
        check_word(word_t'(rd_cnt), 32'd1, "mem_rd count after write-back");
        check_word(rd_addr, make_addr(1, 0, 0, 0), "refill base after write-back");
        finish_test("dirty eviction", errs);

        errs = err_cnt;
        load_check(make_addr(2, 0, 0, 0), SZ_W, "load over clean victim");
        check_word(word_t'(wr_cnt), 32'd0, "mem_wr count on clean eviction");
        check_word(word_t'(rd_cnt), 32'd1, "mem_rd count on clean eviction");
        check_word(rd_addr, make_addr(2, 0, 0, 0), "refill base on clean eviction");
        finish_test("clean eviction", errs);

        errs = err_cnt;
        for (int b = 0; b < 4; b++) begin
            store_ref(make_addr(3, 1, 0, b), rand_bits(32) | ((b % 2 == 0) ? 32'h80 : 0), SZ_B);
        end
        for (int h = 0; h < 2; h++) begin
            store_ref(make_addr(3, 1, 1, 2 * h), rand_bits(32) | (h == 0 ? 32'h8000 : 0), SZ_H);
        end
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < 4; b++) begin
                load_check(make_addr(3, 1, w, b), SZ_B, "signed byte");
                load_check(make_addr(3, 1, w, b), SZ_BU, "unsigned byte");
            end
            for (int h = 0; h < 2; h++) begin
                load_check(make_addr(3, 1, w, 2 * h), SZ_H, "signed half");
                load_check(make_addr(3, 1, w, 2 * h), SZ_HU, "unsigned half");
            end
        end
        load_check(make_addr(3, 1, 0, 0), size_e'(3'b011), "unsupported load code");
        finish_test("byte and halfword lanes", errs);

        errs = err_cnt;
        for (int n = 0; n < 400; n++) begin
            r = rand_bits(8);  // write 1, tag 2, index 1, word 2, byte 2
            if (r[7]) begin
                code = 3'(rand_bits(2));  // Store codes 000 to 011
            end else begin
                code = 3'(rand_bits(3));
            end
            f3   = size_e'(code);
            boff = (f3 == SZ_B || f3 == SZ_BU) ? int'(r[1:0])
                 : (f3 == SZ_H || f3 == SZ_HU) ? int'(r[1]) * 2 : 0;
            if (r[7]) begin
                store_ref(make_addr(r[6:5], r[4], r[3:2], boff), rand_bits(32), f3);
            end else begin
                load_check(make_addr(r[6:5], r[4], r[3:2], boff), f3, "random load");
            end
        end
        for (int t = 0; t < 4; t++) begin
            for (int x = 0; x < 2; x++) begin
                for (int w = 0; w < WORDS_PER_LINE; w++) begin
                    load_check(make_addr(t, x, w, 0), SZ_W, "final sweep");
                end
            end
        end
        finish_test("random mix and sweep", errs);

        asrt = DUT.u_checker.fail_cnt;
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_cnt, test_fail, check_cnt, err_cnt, asrt);
        if (err_cnt == 0 && test_fail == 0 && asrt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: files.f
src/cache_cfg_pkg.sv
src/cache_op_pkg.sv
src/cache_store_if.sv
src/cache_fsm.sv
src/beat_counter.sv
src/cache_store.sv
src/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - src/cache_cfg_pkg.sv
  - src/cache_op_pkg.sv
  - src/cache_store_if.sv
  - src/cache_fsm.sv
  - src/beat_counter.sv
  - src/cache_store.sv
  - src/dcache_top.sv
  - target: test
    files:
      - verification/dcache_checker.sv
      - verification/dcache_tb.sv
